//--- Makefile
# Verilator build and run of the stack store testbench
# The run fails with a nonzero status when the testbench stops on $fatal

TOP := stk_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): src.f $(wildcard *.sv *.svh)
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f src.f

lint:
	verilator --lint-only -Wall +incdir+. --top-module stk_top \
	  stk_mem_pkg.sv stk_uc_pkg.sv stk_sram.sv stk_free_list.sv \
	  stk_pipe_admit.sv stk_pipe_mem.sv stk_pipe_wrbk.sv stk_top.sv

clean:
	rm -rf obj_dir

//--- src.f
+incdir+.
stk_mem_pkg.sv
stk_uc_pkg.sv
stk_sram.sv
stk_free_list.sv
stk_pipe_admit.sv
stk_pipe_mem.sv
stk_pipe_wrbk.sv
stk_top.sv
stk_tb.sv

//--- stk_free_list.sv
// Stack of free line pointers, full after reset
// Caller must not allocate when empty
`default_nettype none
`timescale 1ns/1ps

`include "stk_macros.svh"

module stk_free_list (
  input wire logic              i_clk
, input wire logic              i_rst
, input wire logic              i_alloc
, output stk_mem_pkg::ptr_u     o_alloc_ptr
, output logic                  o_empty
, input wire logic              i_rel
, input wire stk_mem_pkg::ptr_u i_rel_ptr
);

  import stk_mem_pkg::*;

  localparam int LINES_N = 2 ** `STK_PTR_W;

  typedef logic [`STK_PTR_W:0] cnt_t;

  ptr_t fl_mem [LINES_N];
  cnt_t cnt_r;
  ptr_t top_idx;

  // Top entry sits one below the count
  assign top_idx = cnt_r[`STK_PTR_W-1:0] - 1'b1;

  assign o_alloc_ptr.flat = fl_mem[top_idx];
  assign o_empty = (cnt_r == '0);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      cnt_r <= cnt_t'(LINES_N);
      for (int i = 0; i < LINES_N; i++) begin
        fl_mem[i] <= ptr_t'(i);
      end
    end else begin
      case ({i_alloc, i_rel})
        // Released line replaces the one taken
        2'b11: fl_mem[top_idx] <= i_rel_ptr.flat;
        2'b10: cnt_r <= cnt_r - 1'b1;
        2'b01: begin
          fl_mem[cnt_r[`STK_PTR_W-1:0]] <= i_rel_ptr.flat;
          cnt_r <= cnt_r + 1'b1;
        end
        default: begin
        end
      endcase
    end
  end

endmodule : stk_free_list

`default_nettype wire

//--- stk_macros.svh
// Sizing constants for the stack pool
// STK_PTR_W must equal STK_LINE_W plus log2 of STK_BANKS_N
`ifndef STK_MACROS_SVH
`define STK_MACROS_SVH

// SRAM banks, picked by the lowest pointer bit
`define STK_BANKS_N 2

// Engines, one stack each
`define STK_ENGS_N 4

// Line pointer width, 32 lines in the pool
`define STK_PTR_W 5

// Row index within one bank
`define STK_LINE_W 4

// Payload word
`define STK_DAT_W 32

`endif

//--- stk_mem_pkg.sv
// Storage types for the shared line pool
// Pointer bit 0 is the bank, the upper bits are the row in that bank
`default_nettype none

`include "stk_macros.svh"

package stk_mem_pkg;

  // Flat line pointer into the whole pool
  typedef logic [`STK_PTR_W-1:0] ptr_t;

  // Row within one bank
  typedef logic [`STK_LINE_W-1:0] line_id_t;

  // Bank number
  typedef logic [$clog2(`STK_BANKS_N)-1:0] bankid_t;

  // Engine number
  typedef logic [$clog2(`STK_ENGS_N)-1:0] engid_t;

  // Pointer as seen by the SRAM path
  typedef struct packed {
    line_id_t line;
    bankid_t  bank;
  } ptr_split_t;

  // Free list uses flat, SRAM path uses split
  typedef union packed {
    ptr_t       flat;
    ptr_split_t split;
  } ptr_u;

endpackage : stk_mem_pkg

`default_nettype wire

//--- stk_pipe_admit.sv
// Admit stage, samples the command then decodes against the head table
// Same-engine commands need 3 cycles spacing, heads are not forwarded
`default_nettype none
`timescale 1ns/1ps

`include "stk_macros.svh"

module stk_pipe_admit (
  input wire logic                                     i_clk
, input wire logic                                     i_rst
// Command
, input wire logic                                     i_cmd_vld
, input wire stk_mem_pkg::engid_t                      i_cmd_engid
, input wire stk_uc_pkg::opcode_t                      i_cmd_opcode
, input wire logic [`STK_DAT_W-1:0]                    i_cmd_dat
// Head table
, input wire logic [`STK_ENGS_N-1:0]                   i_head_vld
, input wire stk_mem_pkg::ptr_t [`STK_ENGS_N-1:0]      i_head_ptr
// Free list
, output logic                                         o_alloc
, input wire stk_mem_pkg::ptr_u                        i_alloc_ptr
, input wire logic                                     i_fl_empty
// Prev pointer SRAM
, output logic [`STK_BANKS_N-1:0]                      o_prev_ce
, output logic [`STK_BANKS_N-1:0]                      o_prev_we
, output stk_mem_pkg::line_id_t                        o_prev_addr
, output stk_mem_pkg::ptr_t                            o_prev_din
// Data SRAM
, output logic [`STK_BANKS_N-1:0]                      o_dat_ce
, output logic [`STK_BANKS_N-1:0]                      o_dat_we
, output stk_mem_pkg::line_id_t                        o_dat_addr
, output logic [`STK_DAT_W-1:0]                        o_dat_din
// Microcode to memory stage
, output logic                                         o_uc_vld
, output stk_mem_pkg::engid_t                          o_uc_engid
, output stk_mem_pkg::bankid_t                         o_uc_bankid
, output stk_uc_pkg::opcode_t                          o_uc_opcode
, output stk_uc_pkg::status_t                          o_uc_status
, output logic                                         o_uc_head_vld
, output logic                                         o_uc_head_dord
, output stk_mem_pkg::ptr_t                            o_uc_head_ptr
);

  import stk_mem_pkg::*;
  import stk_uc_pkg::*;

  typedef logic [`STK_BANKS_N-1:0] bank_vec_t;

  logic                  cmd_vld_r;
  engid_t                cmd_engid_r;
  opcode_t               cmd_opcode_r;
  logic [`STK_DAT_W-1:0] cmd_dat_r;

  logic      is_push;
  logic      cur_head_vld;
  ptr_u      head_u;
  ptr_u      line_u;
  status_t   status;
  logic      cmd_ok;
  bank_vec_t bank_sel;

  // Command capture
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      cmd_vld_r <= 1'b0;
    end else begin
      cmd_vld_r <= i_cmd_vld;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_cmd_vld) begin
      cmd_engid_r  <= i_cmd_engid;
      cmd_opcode_r <= i_cmd_opcode;
      cmd_dat_r    <= i_cmd_dat;
    end
  end

  // Head lookup for the captured engine
  assign is_push      = (cmd_opcode_r == OPCODE_PUSH);
  assign cur_head_vld = i_head_vld[cmd_engid_r];
  assign head_u.flat  = i_head_ptr[cmd_engid_r];

  always_comb begin
    if (is_push) begin
      status = i_fl_empty ? STATUS_FULL : STATUS_OK;
    end else begin
      status = cur_head_vld ? STATUS_OK : STATUS_EMPTY;
    end
  end

  assign cmd_ok  = cmd_vld_r && (status == STATUS_OK);
  assign o_alloc = cmd_ok && is_push;

  // Push targets the new line, pop the current head
  assign line_u   = is_push ? i_alloc_ptr : head_u;
  assign bank_sel = cmd_ok ? (bank_vec_t'(1) << line_u.split.bank) : '0;

  // Strobes, failed commands leave the SRAMs idle
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_prev_ce <= '0;
      o_prev_we <= '0;
      o_dat_ce  <= '0;
      o_dat_we  <= '0;
      o_uc_vld  <= 1'b0;
    end else begin
      o_prev_ce <= bank_sel;
      o_prev_we <= is_push ? bank_sel : '0;
      o_dat_ce  <= bank_sel;
      o_dat_we  <= is_push ? bank_sel : '0;
      o_uc_vld  <= cmd_vld_r;
    end
  end

  always_ff @(posedge i_clk) begin
    if (cmd_vld_r) begin
      o_prev_addr    <= line_u.split.line;
      // First line of a stack points at itself
      o_prev_din     <= cur_head_vld ? head_u.flat : i_alloc_ptr.flat;
      o_dat_addr     <= line_u.split.line;
      o_dat_din      <= cmd_dat_r;
      o_uc_engid     <= cmd_engid_r;
      o_uc_bankid    <= line_u.split.bank;
      o_uc_opcode    <= cmd_opcode_r;
      o_uc_status    <= status;
      o_uc_head_vld  <= cmd_ok;
      // Pop takes the new head from the prev SRAM
      o_uc_head_dord <= !is_push;
      o_uc_head_ptr  <= line_u.flat;
    end
  end

endmodule : stk_pipe_admit

`default_nettype wire

//--- stk_pipe_mem.sv
// Memory stage, banked prev pointer and data SRAMs
// Writeback microcode is combinational from the stage registers
`default_nettype none
`timescale 1ns/1ps

`include "stk_macros.svh"

module stk_pipe_mem (
  input wire logic                                     i_clk
, input wire logic                                     i_rst
// Prev pointer SRAM
, input wire logic [`STK_BANKS_N-1:0]                  i_prev_ce
, input wire logic [`STK_BANKS_N-1:0]                  i_prev_we
, input wire stk_mem_pkg::line_id_t                    i_prev_addr
, input wire stk_mem_pkg::ptr_t                        i_prev_din
// Data SRAM
, input wire logic [`STK_BANKS_N-1:0]                  i_dat_ce
, input wire logic [`STK_BANKS_N-1:0]                  i_dat_we
, input wire stk_mem_pkg::line_id_t                    i_dat_addr
, input wire logic [`STK_DAT_W-1:0]                    i_dat_din
// Microcode from admit
, input wire logic                                     i_uc_vld
, input wire stk_mem_pkg::engid_t                      i_uc_engid
, input wire stk_mem_pkg::bankid_t                     i_uc_bankid
, input wire stk_uc_pkg::opcode_t                      i_uc_opcode
, input wire stk_uc_pkg::status_t                      i_uc_status
, input wire logic                                     i_uc_head_vld
, input wire logic                                     i_uc_head_dord
, input wire stk_mem_pkg::ptr_t                        i_uc_head_ptr
// Microcode to writeback
, output logic                                         o_wrbk_uc_vld
, output stk_mem_pkg::engid_t                          o_wrbk_uc_engid
, output stk_uc_pkg::status_t                          o_wrbk_uc_status
, output logic                                         o_wrbk_uc_head_vld
, output stk_mem_pkg::ptr_t                            o_wrbk_uc_head_ptr
, output stk_mem_pkg::ptr_t                            o_wrbk_uc_rel_ptr
, output logic                                         o_wrbk_uc_dat_vld
, output logic [`STK_DAT_W-1:0]                        o_wrbk_uc_dat
);

  import stk_mem_pkg::*;
  import stk_uc_pkg::*;

  ptr_t                  prev_dout [`STK_BANKS_N];
  logic [`STK_DAT_W-1:0] dat_dout [`STK_BANKS_N];
  ptr_t                  prev_ptr;

  logic    mdat_uc_vld_r;
  engid_t  mdat_uc_engid_r;
  bankid_t mdat_uc_bankid_r;
  opcode_t mdat_uc_opcode_r;
  status_t mdat_uc_status_r;
  logic    mdat_uc_head_vld_r;
  logic    mdat_uc_head_dord_r;
  ptr_t    mdat_uc_head_ptr_r;

  // One prev and one data SRAM per bank
  for (genvar bnk = 0; bnk < `STK_BANKS_N; bnk++) begin : g_bank
    stk_sram #(.W(`STK_PTR_W)) u_prev_sram (
      .i_clk  (i_clk)
    , .i_ce   (i_prev_ce[bnk])
    , .i_we   (i_prev_we[bnk])
    , .i_addr (i_prev_addr)
    , .i_din  (i_prev_din)
    , .o_dout (prev_dout[bnk])
    );

    stk_sram #(.W(`STK_DAT_W)) u_dat_sram (
      .i_clk  (i_clk)
    , .i_ce   (i_dat_ce[bnk])
    , .i_we   (i_dat_we[bnk])
    , .i_addr (i_dat_addr)
    , .i_din  (i_dat_din)
    , .o_dout (dat_dout[bnk])
    );
  end : g_bank

  // Microcode registered alongside the SRAM read
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      mdat_uc_vld_r <= 1'b0;
    end else begin
      mdat_uc_vld_r <= i_uc_vld;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_uc_vld) begin
      mdat_uc_engid_r     <= i_uc_engid;
      mdat_uc_bankid_r    <= i_uc_bankid;
      mdat_uc_opcode_r    <= i_uc_opcode;
      mdat_uc_status_r    <= i_uc_status;
      mdat_uc_head_vld_r  <= i_uc_head_vld;
      mdat_uc_head_dord_r <= i_uc_head_dord;
      mdat_uc_head_ptr_r  <= i_uc_head_ptr;
    end
  end

  // Read bank from the registered bank id
  assign prev_ptr = prev_dout[mdat_uc_bankid_r];

  assign o_wrbk_uc_vld      = mdat_uc_vld_r;
  assign o_wrbk_uc_engid    = mdat_uc_engid_r;
  assign o_wrbk_uc_status   = mdat_uc_status_r;
  assign o_wrbk_uc_head_vld = mdat_uc_head_vld_r;
  assign o_wrbk_uc_head_ptr = mdat_uc_head_dord_r ? prev_ptr : mdat_uc_head_ptr_r;

  // Old head of a pop goes back to the free list
  assign o_wrbk_uc_rel_ptr = mdat_uc_head_ptr_r;

  // Data only on a successful pop
  assign o_wrbk_uc_dat_vld = mdat_uc_vld_r
                          && (mdat_uc_opcode_r == OPCODE_POP)
                          && (mdat_uc_status_r == STATUS_OK);
  assign o_wrbk_uc_dat     = dat_dout[mdat_uc_bankid_r];

endmodule : stk_pipe_mem

`default_nettype wire

//--- stk_pipe_wrbk.sv
// Writeback stage, head table, line release and response
// Release is combinational, the free list takes it at the response edge
`default_nettype none
`timescale 1ns/1ps

`include "stk_macros.svh"

module stk_pipe_wrbk (
  input wire logic                                     i_clk
, input wire logic                                     i_rst
// Microcode from memory stage
, input wire logic                                     i_wrbk_uc_vld
, input wire stk_mem_pkg::engid_t                      i_wrbk_uc_engid
, input wire stk_uc_pkg::status_t                      i_wrbk_uc_status
, input wire logic                                     i_wrbk_uc_head_vld
, input wire stk_mem_pkg::ptr_t                        i_wrbk_uc_head_ptr
, input wire stk_mem_pkg::ptr_t                        i_wrbk_uc_rel_ptr
, input wire logic                                     i_wrbk_uc_dat_vld
, input wire logic [`STK_DAT_W-1:0]                    i_wrbk_uc_dat
// Head table
, output logic [`STK_ENGS_N-1:0]                       o_head_vld
, output stk_mem_pkg::ptr_t [`STK_ENGS_N-1:0]          o_head_ptr
// Free list release
, output logic                                         o_rel
, output stk_mem_pkg::ptr_u                            o_rel_ptr
// Response
, output logic                                         o_rsp_vld
, output stk_mem_pkg::engid_t                          o_rsp_engid
, output stk_uc_pkg::status_t                          o_rsp_status
, output logic                                         o_rsp_dat_vld
, output logic [`STK_DAT_W-1:0]                        o_rsp_dat
);

  import stk_uc_pkg::*;

  logic upd;
  logic bottom;

  assign upd = i_wrbk_uc_vld && (i_wrbk_uc_status == STATUS_OK);

  // Bottom line points at itself
  assign bottom = i_wrbk_uc_dat_vld && (i_wrbk_uc_head_ptr == i_wrbk_uc_rel_ptr);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_head_vld <= '0;
    end else if (upd) begin
      o_head_vld[i_wrbk_uc_engid] <= i_wrbk_uc_head_vld && !bottom;
    end
  end

  always_ff @(posedge i_clk) begin
    if (upd) begin
      o_head_ptr[i_wrbk_uc_engid] <= i_wrbk_uc_head_ptr;
    end
  end

  // Popped line returns to the pool
  assign o_rel          = i_wrbk_uc_vld && i_wrbk_uc_dat_vld;
  assign o_rel_ptr.flat = i_wrbk_uc_rel_ptr;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_rsp_vld <= 1'b0;
    end else begin
      o_rsp_vld <= i_wrbk_uc_vld;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_wrbk_uc_vld) begin
      o_rsp_engid   <= i_wrbk_uc_engid;
      o_rsp_status  <= i_wrbk_uc_status;
      o_rsp_dat_vld <= i_wrbk_uc_dat_vld;
      o_rsp_dat     <= i_wrbk_uc_dat;
    end
  end

endmodule : stk_pipe_wrbk

`default_nettype wire

//--- stk_sram.sv
// Single-port SRAM, 16 rows, registered read data
// Read data holds until the next read
`default_nettype none
`timescale 1ns/1ps

`include "stk_macros.svh"

module stk_sram #(
  parameter int W = 32
) (
  input wire logic                  i_clk
, input wire logic                  i_ce
, input wire logic                  i_we
, input wire stk_mem_pkg::line_id_t i_addr
, input wire logic [W-1:0]          i_din
, output logic [W-1:0]              o_dout
);

  localparam int ROWS_N = 2 ** `STK_LINE_W;

  logic [W-1:0] mem [ROWS_N];

  // Write on enable with write set, else read
  always_ff @(posedge i_clk) begin
    if (i_ce && i_we) begin
      mem[i_addr] <= i_din;
    end else if (i_ce) begin
      o_dout <= mem[i_addr];
    end
  end

endmodule : stk_sram

`default_nettype wire

//--- stk_tb.sv
// Testbench for stk_top with a directed table, an engine burst and a random mix
// Same-engine commands are always issued at least 3 cycles apart
`default_nettype none
`timescale 1ns/1ps

`include "stk_macros.svh"

module stk_tb;

  import stk_mem_pkg::*;
  import stk_uc_pkg::*;

  localparam int LINES_N  = 2 ** `STK_PTR_W;
  localparam int ENGS_N   = `STK_ENGS_N;
  localparam int LAT      = 3;
  localparam int RSP_TMO  = 10;
  localparam int RAND_CYC = 400;

  // One directed command and its expected response
  typedef struct {
    engid_t                engid;
    opcode_t               opcode;
    logic [`STK_DAT_W-1:0] dat;
    status_t               status;
    logic                  dat_vld;
    logic [`STK_DAT_W-1:0] exp_dat;
  } row_t;

  // Pending response and the edge it must appear at
  typedef struct {
    int                    due;
    engid_t                engid;
    status_t               status;
    logic                  dat_vld;
    logic [`STK_DAT_W-1:0] dat;
  } rsp_t;

  logic                  clk;
  logic                  rst;
  logic                  cmd_vld;
  engid_t                cmd_engid;
  opcode_t               cmd_opcode;
  logic [`STK_DAT_W-1:0] cmd_dat;
  logic                  rsp_vld;
  engid_t                rsp_engid;
  status_t               rsp_status;
  logic                  rsp_dat_vld;
  logic [`STK_DAT_W-1:0] rsp_dat;

  row_t                  tbl [$];
  rsp_t                  exp_q [$];
  int                    cyc;
  logic [15:0]           lfsr_st;

  // Reference model of four stacks over one pool of lines
  logic [`STK_DAT_W-1:0] model_stk [ENGS_N][$];
  int                    free_cnt;
  int                    rel_due [$];
  int                    last_s [ENGS_N];

  stk_top uut (
    .i_clk         (clk)
  , .i_rst         (rst)
  , .i_cmd_vld     (cmd_vld)
  , .i_cmd_engid   (cmd_engid)
  , .i_cmd_opcode  (cmd_opcode)
  , .i_cmd_dat     (cmd_dat)
  , .o_rsp_vld     (rsp_vld)
  , .o_rsp_engid   (rsp_engid)
  , .o_rsp_status  (rsp_status)
  , .o_rsp_dat_vld (rsp_dat_vld)
  , .o_rsp_dat     (rsp_dat)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      fail_run($sformatf("** Error at %0d ns: %s is %0h, expected %0h",
                         $time, what, got, exp));
    end
  endtask

  // Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_st = lfsr_next(lfsr_st);
      v = {v[30:0], lfsr_st[0]};
    end
  endtask

  function automatic logic [31:0] pool_word(input int i);
    return 32'hA500_0000 | 32'(i);
  endfunction

  // Advance one edge and check any response it produced
  task automatic step();
    rsp_t exp;
    @(posedge clk);
    cyc++;
    #1;
    if (rsp_vld === 1'b1) begin
      check_value(32'(exp_q.size() > 0), 32'd1, "response with nothing pending");
      exp = exp_q.pop_front();
      check_value(32'(cyc), 32'(exp.due), "response edge");
      check_value(32'(rsp_engid), 32'(exp.engid), "response engine");
      check_value(32'(rsp_status), 32'(exp.status), "response status");
      check_value(32'(rsp_dat_vld), 32'(exp.dat_vld), "response data valid");
      if (exp.dat_vld) begin
        check_value(rsp_dat, exp.dat, "response data");
      end
    end
  endtask

  // Drive one command for the next edge to sample
  task automatic send(input engid_t e, input opcode_t op, input logic [31:0] d,
                      input status_t st, input logic dv, input logic [31:0] xd);
    rsp_t r;
    cmd_vld    = 1'b1;
    cmd_engid  = e;
    cmd_opcode = op;
    cmd_dat    = d;
    r.due      = cyc + 1 + LAT;
    r.engid    = e;
    r.status   = st;
    r.dat_vld  = dv;
    r.dat      = xd;
    exp_q.push_back(r);
  endtask

  task automatic idle();
    cmd_vld = 1'b0;
  endtask

  task automatic wait_drain(input string what);
    int n;
    n = 0;
    while (exp_q.size() != 0) begin
      if (n == RSP_TMO) begin
        fail_run($sformatf("Timeout: no response arrived for %s within %0d cycles",
                           what, RSP_TMO));
      end
      step();
      n++;
    end
  endtask

  // Model decides the outcome at the edge the command is sampled on
  task automatic model_issue(input engid_t e, input opcode_t op, input logic [31:0] d);
    int          s;
    status_t     st;
    logic        dv;
    logic [31:0] xd;
    s  = cyc + 1;
    dv = 1'b0;
    xd = '0;
    // Popped lines return to the pool 3 edges after their pop
    while (rel_due.size() != 0 && rel_due[0] <= s) begin
      void'(rel_due.pop_front());
      free_cnt++;
    end
    if (op == OPCODE_PUSH) begin
      if (free_cnt > 0) begin
        st = STATUS_OK;
        free_cnt--;
        model_stk[e].push_back(d);
      end else begin
        st = STATUS_FULL;
      end
    end else if (model_stk[e].size() > 0) begin
      st = STATUS_OK;
      dv = 1'b1;
      xd = model_stk[e].pop_back();
      rel_due.push_back(s + LAT);
    end else begin
      st = STATUS_EMPTY;
    end
    last_s[e] = s;
    send(e, op, d, st, dv, xd);
  endtask

  task automatic add_row(input int e, input opcode_t op, input logic [31:0] d,
                         input status_t st, input logic dv, input logic [31:0] xd);
    row_t r;
    r.engid   = engid_t'(e);
    r.opcode  = op;
    r.dat     = d;
    r.status  = st;
    r.dat_vld = dv;
    r.exp_dat = xd;
    tbl.push_back(r);
  endtask

  task automatic build_table();
    logic [31:0] d;
    // LIFO order on engine 0
    for (int i = 0; i < 3; i++) begin
      add_row(0, OPCODE_PUSH, 32'hC0DE_0000 + 32'(i), STATUS_OK, 1'b0, '0);
    end
    for (int i = 2; i >= 0; i--) begin
      add_row(0, OPCODE_POP, '0, STATUS_OK, 1'b1, 32'hC0DE_0000 + 32'(i));
    end
    // Empty pop and then a stack that still works
    add_row(1, OPCODE_POP, '0, STATUS_EMPTY, 1'b0, '0);
    add_row(1, OPCODE_PUSH, 32'h1234_5678, STATUS_OK, 1'b0, '0);
    add_row(1, OPCODE_POP, '0, STATUS_OK, 1'b1, 32'h1234_5678);
    add_row(1, OPCODE_POP, '0, STATUS_EMPTY, 1'b0, '0);
    // Fill all lines round robin over the engines
    for (int i = 0; i < LINES_N; i++) begin
      add_row(i % ENGS_N, OPCODE_PUSH, pool_word(i), STATUS_OK, 1'b0, '0);
    end
    add_row(0, OPCODE_PUSH, 32'hDEAD_BEEF, STATUS_FULL, 1'b0, '0);
    // One pop frees a line for the next push
    add_row(3, OPCODE_POP, '0, STATUS_OK, 1'b1, pool_word(LINES_N - 1));
    add_row(3, OPCODE_PUSH, 32'h5A5A_0031, STATUS_OK, 1'b0, '0);
    add_row(2, OPCODE_PUSH, 32'hDEAD_BEEF, STATUS_FULL, 1'b0, '0);
    // Drain everything with the refill word on top of engine 3
    for (int e = 0; e < ENGS_N; e++) begin
      for (int k = LINES_N / ENGS_N - 1; k >= 0; k--) begin
        d = (e == 3 && k == LINES_N / ENGS_N - 1) ? 32'h5A5A_0031
                                                   : pool_word(e + ENGS_N * k);
        add_row(e, OPCODE_POP, '0, STATUS_OK, 1'b1, d);
      end
    end
    for (int e = 0; e < ENGS_N; e++) begin
      add_row(e, OPCODE_POP, '0, STATUS_EMPTY, 1'b0, '0);
    end
  endtask

  initial begin
    logic [31:0] r_issue;
    logic [31:0] r_eng;
    logic [31:0] r_op;
    logic [31:0] r_dat;
    engid_t      e;
    rst        = 1'b1;
    cmd_vld    = 1'b0;
    cmd_engid  = '0;
    cmd_opcode = OPCODE_PUSH;
    cmd_dat    = '0;
    cyc        = 0;
    lfsr_st    = 16'd17;
    for (int i = 0; i < 8; i++) begin
      step();
    end
    rst = 1'b0;

    // Idle after reset where any response is an error
    for (int i = 0; i < 4; i++) begin
      step();
    end

    build_table();
    foreach (tbl[i]) begin
      step();
      send(tbl[i].engid, tbl[i].opcode, tbl[i].dat, tbl[i].status,
           tbl[i].dat_vld, tbl[i].exp_dat);
      step();
      idle();
      wait_drain($sformatf("table row %0d", i));
    end

    // Pool is whole again and the model starts empty
    free_cnt = LINES_N;
    for (int i = 0; i < ENGS_N; i++) begin
      last_s[i] = -LAT;
    end

    // Back to back commands over all engines
    for (int i = 0; i < ENGS_N; i++) begin
      step();
      model_issue(engid_t'(i), OPCODE_PUSH, 32'hB000_0000 + 32'(i));
    end
    for (int i = 0; i < ENGS_N; i++) begin
      step();
      model_issue(engid_t'(i), OPCODE_POP, '0);
    end
    step();
    idle();
    wait_drain("engine burst");

    // Random mix with pushes favoured so the pool fills now and then
    for (int k = 0; k < RAND_CYC; k++) begin
      step();
      draw_bits(2, r_issue);
      draw_bits(2, r_eng);
      draw_bits(3, r_op);
      draw_bits(32, r_dat);
      e = engid_t'(r_eng);
      if (r_issue != 0 && cyc + 1 - last_s[e] >= LAT) begin
        model_issue(e, (r_op < 3) ? OPCODE_POP : OPCODE_PUSH, r_dat);
      end else begin
        idle();
      end
    end
    step();
    idle();
    wait_drain("random mix");

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule : stk_tb

`default_nettype wire

//--- stk_top.sv
// Linked-list stack store, response 3 cycles after each command
// No back-pressure, same-engine commands at least 3 cycles apart
`default_nettype none
`timescale 1ns/1ps

`include "stk_macros.svh"

module stk_top (
  input wire logic                   i_clk
, input wire logic                   i_rst
, input wire logic                   i_cmd_vld
, input wire stk_mem_pkg::engid_t    i_cmd_engid
, input wire stk_uc_pkg::opcode_t    i_cmd_opcode
, input wire logic [`STK_DAT_W-1:0]  i_cmd_dat
, output logic                       o_rsp_vld
, output stk_mem_pkg::engid_t        o_rsp_engid
, output stk_uc_pkg::status_t        o_rsp_status
, output logic                       o_rsp_dat_vld
, output logic [`STK_DAT_W-1:0]      o_rsp_dat
);

  import stk_mem_pkg::*;
  import stk_uc_pkg::*;

  // Head table and free list
  logic [`STK_ENGS_N-1:0]    head_vld;
  ptr_t [`STK_ENGS_N-1:0]    head_ptr;
  logic                      alloc;
  ptr_u                      alloc_ptr;
  logic                      fl_empty;
  logic                      rel;
  ptr_u                      rel_ptr;

  // Admit to memory
  logic [`STK_BANKS_N-1:0]   prev_ce;
  logic [`STK_BANKS_N-1:0]   prev_we;
  line_id_t                  prev_addr;
  ptr_t                      prev_din;
  logic [`STK_BANKS_N-1:0]   dat_ce;
  logic [`STK_BANKS_N-1:0]   dat_we;
  line_id_t                  dat_addr;
  logic [`STK_DAT_W-1:0]     dat_din;
  logic                      uc_vld;
  engid_t                    uc_engid;
  bankid_t                   uc_bankid;
  opcode_t                   uc_opcode;
  status_t                   uc_status;
  logic                      uc_head_vld;
  logic                      uc_head_dord;
  ptr_t                      uc_head_ptr;

  // Memory to writeback
  logic                      wrbk_uc_vld;
  engid_t                    wrbk_uc_engid;
  status_t                   wrbk_uc_status;
  logic                      wrbk_uc_head_vld;
  ptr_t                      wrbk_uc_head_ptr;
  ptr_t                      wrbk_uc_rel_ptr;
  logic                      wrbk_uc_dat_vld;
  logic [`STK_DAT_W-1:0]     wrbk_uc_dat;

  stk_pipe_admit u_admit (
    .i_clk          (i_clk)
  , .i_rst          (i_rst)
  , .i_cmd_vld      (i_cmd_vld)
  , .i_cmd_engid    (i_cmd_engid)
  , .i_cmd_opcode   (i_cmd_opcode)
  , .i_cmd_dat      (i_cmd_dat)
  , .i_head_vld     (head_vld)
  , .i_head_ptr     (head_ptr)
  , .o_alloc        (alloc)
  , .i_alloc_ptr    (alloc_ptr)
  , .i_fl_empty     (fl_empty)
  , .o_prev_ce      (prev_ce)
  , .o_prev_we      (prev_we)
  , .o_prev_addr    (prev_addr)
  , .o_prev_din     (prev_din)
  , .o_dat_ce       (dat_ce)
  , .o_dat_we       (dat_we)
  , .o_dat_addr     (dat_addr)
  , .o_dat_din      (dat_din)
  , .o_uc_vld       (uc_vld)
  , .o_uc_engid     (uc_engid)
  , .o_uc_bankid    (uc_bankid)
  , .o_uc_opcode    (uc_opcode)
  , .o_uc_status    (uc_status)
  , .o_uc_head_vld  (uc_head_vld)
  , .o_uc_head_dord (uc_head_dord)
  , .o_uc_head_ptr  (uc_head_ptr)
  );

  stk_free_list u_free_list (
    .i_clk       (i_clk)
  , .i_rst       (i_rst)
  , .i_alloc     (alloc)
  , .o_alloc_ptr (alloc_ptr)
  , .o_empty     (fl_empty)
  , .i_rel       (rel)
  , .i_rel_ptr   (rel_ptr)
  );

  stk_pipe_mem u_mem (
    .i_clk              (i_clk)
  , .i_rst              (i_rst)
  , .i_prev_ce          (prev_ce)
  , .i_prev_we          (prev_we)
  , .i_prev_addr        (prev_addr)
  , .i_prev_din         (prev_din)
  , .i_dat_ce           (dat_ce)
  , .i_dat_we           (dat_we)
  , .i_dat_addr         (dat_addr)
  , .i_dat_din          (dat_din)
  , .i_uc_vld           (uc_vld)
  , .i_uc_engid         (uc_engid)
  , .i_uc_bankid        (uc_bankid)
  , .i_uc_opcode        (uc_opcode)
  , .i_uc_status        (uc_status)
  , .i_uc_head_vld      (uc_head_vld)
  , .i_uc_head_dord     (uc_head_dord)
  , .i_uc_head_ptr      (uc_head_ptr)
  , .o_wrbk_uc_vld      (wrbk_uc_vld)
  , .o_wrbk_uc_engid    (wrbk_uc_engid)
  , .o_wrbk_uc_status   (wrbk_uc_status)
  , .o_wrbk_uc_head_vld (wrbk_uc_head_vld)
  , .o_wrbk_uc_head_ptr (wrbk_uc_head_ptr)
  , .o_wrbk_uc_rel_ptr  (wrbk_uc_rel_ptr)
  , .o_wrbk_uc_dat_vld  (wrbk_uc_dat_vld)
  , .o_wrbk_uc_dat      (wrbk_uc_dat)
  );

  stk_pipe_wrbk u_wrbk (
    .i_clk              (i_clk)
  , .i_rst              (i_rst)
  , .i_wrbk_uc_vld      (wrbk_uc_vld)
  , .i_wrbk_uc_engid    (wrbk_uc_engid)
  , .i_wrbk_uc_status   (wrbk_uc_status)
  , .i_wrbk_uc_head_vld (wrbk_uc_head_vld)
  , .i_wrbk_uc_head_ptr (wrbk_uc_head_ptr)
  , .i_wrbk_uc_rel_ptr  (wrbk_uc_rel_ptr)
  , .i_wrbk_uc_dat_vld  (wrbk_uc_dat_vld)
  , .i_wrbk_uc_dat      (wrbk_uc_dat)
  , .o_head_vld         (head_vld)
  , .o_head_ptr         (head_ptr)
  , .o_rel              (rel)
  , .o_rel_ptr          (rel_ptr)
  , .o_rsp_vld          (o_rsp_vld)
  , .o_rsp_engid        (o_rsp_engid)
  , .o_rsp_status       (o_rsp_status)
  , .o_rsp_dat_vld      (o_rsp_dat_vld)
  , .o_rsp_dat          (o_rsp_dat)
  );

endmodule : stk_top

`default_nettype wire

//--- stk_uc_pkg.sv
// Microcode encodings shared by the pipeline stages
`default_nettype none

package stk_uc_pkg;

  // Command opcode
  typedef enum logic {
    OPCODE_PUSH = 1'b0,
    OPCODE_POP  = 1'b1
  } opcode_t;

  // Command outcome
  typedef enum logic [1:0] {
    // Command completed
    STATUS_OK    = 2'd0,
    // Push with no free line
    STATUS_FULL  = 2'd1,
    // Pop of an empty stack
    STATUS_EMPTY = 2'd2
  } status_t;

endpackage : stk_uc_pkg

`default_nettype wire
